// File: build.f
hdl/exec_pkg.sv
hdl/alu.sv
hdl/branch_resolve.sv
hdl/execute.sv
hdl/op_queue.sv
hdl/result_stage.sv
hdl/exec_top.sv
verif/exec_checker.sv
verif/exec_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - hdl/exec_pkg.sv
  - hdl/alu.sv
  - hdl/branch_resolve.sv
  - hdl/execute.sv
  - hdl/op_queue.sv
  - hdl/result_stage.sv
  - hdl/exec_top.sv
  - target: simulation
    files:
      - verif/exec_checker.sv
      - verif/exec_tb.sv

// File: verif/exec_tb.sv
// Testbench for the execute unit with table-driven operations and credit flow on both ports
module exec_tb import exec_pkg::*; ();

   localparam int DATA_W      = 16;
   localparam int DEPTH       = 4;
   localparam int OUT_CREDITS = 2;
   localparam int EXP_W       = 3*DATA_W + 5;
   localparam int STALL_CYC   = 40;    // Downstream holds credits this long
   localparam int WAIT_MAX    = 200;

   typedef struct {
      int                t;
      alu_op_e           op;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic              cin, inv_a, inv_b, sign;
      br_cond_e          bc;
      logic              br, jmp;
      logic [DATA_W-1:0] pc;
      logic [1:0]        rnd;    // Bit 0 random a, bit 1 random b
      logic              stall;
   } row_t;

   logic              clk, rst, in_valid;
   alu_op_e           in_op;
   logic [DATA_W-1:0] in_a, in_b, in_pc_inc;
   logic              in_cin, in_inv_a, in_inv_b, in_sign, in_br, in_jmp;
   br_cond_e          in_br_cond;
   logic              out_credit, in_credit, out_valid;
   logic [DATA_W-1:0] out_result, out_br_target, out_jr_target;
   logic              out_zero, out_ofl, out_lt, out_lte, out_pc_src;
   int                in_cred, owed, hold, stall_outs, errs;
   logic [31:0]       seed;

   string names [6] = '{"reset", "alu_logic", "shift_rotate", "flags", "branch", "credit_flow"};

   // t, op, a, b, cin, inv_a, inv_b, sign, bc, br, jmp, pc, rnd, stall
   row_t rows [37] = '{
      '{1, OP_ADD, 'h1234, 'h0234, 1, 0, 1, 0, BR_EQ, 0, 0, 'h0000, 0, 0},  // Subtract
      '{1, OP_ADD, 'h5a5a, 'h5a5a, 1, 0, 1, 0, BR_EQ, 0, 0, 'h0000, 0, 0},
      '{1, OP_ADD, 'h0003, 'h0007, 1, 1, 0, 0, BR_EQ, 0, 0, 'h0000, 0, 0},  // b - a
      '{1, OP_OR,  'h0000, 'h0000, 0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 3, 0},
      '{1, OP_XOR, 'hf0f0, 'hf0f0, 0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 0, 0},
      '{1, OP_AND, 'h0000, 'h0000, 0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 3, 0},
      '{2, OP_ROL, 'h0000, 'd0,    0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_ROL, 'h0000, 'd1,    0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_ROL, 'h0000, 'd15,   0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_SLL, 'h0000, 'd0,    0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_SLL, 'h0000, 'd1,    0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_SLL, 'h0000, 'd15,   0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_ROR, 'h0000, 'd0,    0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_ROR, 'h0000, 'd1,    0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_ROR, 'h0000, 'd15,   0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_SRL, 'h0000, 'd0,    0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_SRL, 'h0000, 'd1,    0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{2, OP_SRL, 'h0000, 'd15,   0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 1, 0},
      '{3, OP_ADD, 'h7fff, 'h0001, 0, 0, 0, 1, BR_EQ, 0, 0, 'h0000, 0, 0},  // Signed overflow
      '{3, OP_ADD, 'hffff, 'h0001, 0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 0, 0},  // Carry out
      '{3, OP_ADD, 'h8000, 'hffff, 0, 0, 0, 1, BR_EQ, 0, 0, 'h0000, 0, 0},
      '{3, OP_ADD, 'h7fff, 'h8000, 0, 0, 0, 0, BR_EQ, 0, 0, 'h0000, 0, 0},
      '{3, OP_ADD, 'h7fff, 'h8000, 0, 0, 0, 1, BR_EQ, 0, 0, 'h0000, 0, 0},
      '{3, OP_ADD, 'h8000, 'h8000, 0, 0, 0, 1, BR_EQ, 0, 0, 'h0000, 0, 0},  // Equal operands
      '{4, OP_ADD, 'h0040, 'h0040, 1, 0, 1, 0, BR_EQ,  1, 0, 'h0100, 0, 0},
      '{4, OP_ADD, 'h0040, 'h0040, 1, 0, 1, 0, BR_NEQ, 1, 0, 'h0200, 0, 0},
      '{4, OP_ADD, 'h8000, 'h0010, 1, 0, 1, 0, BR_LT,  1, 0, 'h0300, 0, 0},
      '{4, OP_ADD, 'h8000, 'h0010, 1, 0, 1, 0, BR_GTE, 1, 0, 'h0400, 0, 0},
      '{4, OP_ADD, 'h0001, 'h0002, 1, 0, 1, 0, BR_NEQ, 0, 1, 'hfffe, 0, 0},  // Jump, target wraps
      '{4, OP_ADD, 'h0040, 'h0040, 1, 0, 1, 0, BR_EQ,  0, 0, 'h0500, 0, 0},
      '{5, OP_ADD, 'h0000, 'h0000, 0, 0, 0, 0, BR_EQ, 0, 0, 'h0010, 3, 1},   // Starts the stall
      '{5, OP_XOR, 'h0000, 'h0000, 0, 0, 0, 0, BR_NEQ, 1, 0, 'h0020, 3, 0},
      '{5, OP_ROL, 'h0000, 'h0000, 0, 0, 0, 0, BR_LT, 1, 0, 'h0030, 3, 0},
      '{5, OP_ADD, 'h0000, 'h0000, 1, 0, 1, 1, BR_GTE, 1, 0, 'h0040, 3, 0},
      '{5, OP_SRL, 'h0000, 'h0000, 0, 0, 0, 0, BR_EQ, 0, 1, 'h0050, 3, 0},
      '{5, OP_AND, 'h0000, 'h0000, 0, 0, 0, 0, BR_EQ, 0, 0, 'h0060, 3, 0},
      '{5, OP_OR,  'h0000, 'h0000, 0, 0, 0, 0, BR_EQ, 0, 0, 'h0070, 3, 0}
   };

   always #4 clk = ~clk;

   exec_top #(.DATA_W(DATA_W), .DEPTH(DEPTH), .OUT_CREDITS(OUT_CREDITS)) dut0 (.*);

   exec_checker #(.DATA_W(DATA_W)) chk0 (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Expected record straight from the execute rules
   function automatic logic [EXP_W-1:0] expected_of(input row_t r);
      logic [DATA_W-1:0] a, b, res;
      logic [DATA_W:0]   sum;
      int                sh;
      int                sres;
      logic              zero, ofl, lt, lte, take;
      a    = r.inv_a ? ~r.a : r.a;
      b    = r.inv_b ? ~r.b : r.b;
      sh   = b[3:0];
      sum  = a + b + r.cin;
      sres = int'($signed(a)) + int'($signed(b)) + int'(r.cin);   // Exact signed sum
      case (r.op)
         OP_ROL:  res = (a << sh) | (a >> (DATA_W - sh));
         OP_SLL:  res = a << sh;
         OP_ROR:  res = (a >> sh) | (a << (DATA_W - sh));
         OP_SRL:  res = a >> sh;
         OP_ADD:  res = sum[DATA_W-1:0];
         OP_OR:   res = a | b;
         OP_XOR:  res = a ^ b;
         default: res = a & b;
      endcase
      zero = (res == 0);
      ofl  = r.sign ? (sres > 2**(DATA_W-1) - 1 || sres < -(2**(DATA_W-1)))
                    : sum[DATA_W];
      lt   = r.sign ? ($signed(r.a) < $signed(r.b)) : (r.a < r.b);
      lte  = r.sign ? ($signed(r.a) <= $signed(r.b)) : (r.a <= r.b);
      case (r.bc)
         BR_EQ:   take = zero;
         BR_NEQ:  take = !zero;
         BR_LT:   take = r.a[DATA_W-1];
         default: take = !r.a[DATA_W-1];
      endcase
      return {res, zero, ofl, lt, lte, r.jmp | (r.br & take), r.pc + (r.b << 1), r.pc + r.a};
   endfunction

   task automatic abort(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $finish;
   endtask

   // Advance one clock, count returned credits and results, then drive out_credit
   task automatic step();
      @(posedge clk);
      #1;
      in_valid = 0;
      if (in_credit) in_cred++;
      if (in_cred > DEPTH) begin
         errs++;
         $display("more input credits came back than DEPTH allows");
      end
      if (out_valid) begin
         owed++;
         if (hold > 0) stall_outs++;
      end
      if (hold > 0) hold--;
      out_credit = (owed > 0 && hold == 0);
      if (out_credit) owed--;
   endtask

   task automatic wait_credit();
      int n;
      n = 0;
      while (in_cred == 0) begin
         step();
         n++;
         if (n > WAIT_MAX) abort("no input credit came back before the timeout");
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (chk0.pending() != 0 || owed != 0) begin
         step();
         n++;
         if (n > WAIT_MAX) abort("queued results did not arrive before the timeout");
      end
   endtask

   task automatic apply_row(input row_t r_in);
      row_t r;
      r = r_in;
      step();
      wait_credit();
      if (r.stall) hold = STALL_CYC;
      if (r.rnd[0]) begin
         seed = xorshift(seed);
         r.a  = seed[DATA_W-1:0];
      end
      if (r.rnd[1]) begin
         seed = xorshift(seed);
         r.b  = seed[DATA_W-1:0];
      end
      in_valid   = 1;
      in_op      = r.op;
      in_a       = r.a;
      in_b       = r.b;
      in_cin     = r.cin;
      in_inv_a   = r.inv_a;
      in_inv_b   = r.inv_b;
      in_sign    = r.sign;
      in_br_cond = r.bc;
      in_br      = r.br;
      in_jmp     = r.jmp;
      in_pc_inc  = r.pc;
      in_cred--;
      chk0.expect_push(expected_of(r));
   endtask

   task automatic report(input int t, input int c0, input int e0);
      $display("test %0d %s: %0d results checked, %0d errors", t, names[t],
               chk0.chk_cnt - c0, chk0.err_cnt + errs - e0);
   endtask

   initial begin
      int c0;
      int e0;
      clk = 0;
      rst = 1;
      in_valid = 0;
      in_op = OP_ADD;
      in_a = '0;
      in_b = '0;
      in_pc_inc = '0;
      {in_cin, in_inv_a, in_inv_b, in_sign, in_br, in_jmp} = '0;
      in_br_cond = BR_EQ;
      out_credit = 0;
      in_cred = DEPTH;
      {owed, hold, stall_outs, errs} = '0;
      seed = 32'h2dce;
      for (int i = 0; i < 12; i++) begin   // 8 reset cycles plus a few idle
         step();
         if (i == 7) rst = 0;
         chk0.compare("out_valid", out_valid, 0);
         chk0.compare("in_credit", in_credit, 0);
      end
      report(0, 0, 0);
      for (int t = 1; t < 6; t++) begin
         c0 = chk0.chk_cnt;
         e0 = chk0.err_cnt + errs;
         stall_outs = 0;
         foreach (rows[i]) begin
            if (rows[i].t == t) apply_row(rows[i]);
         end
         drain();
         if (t == 5 && stall_outs > OUT_CREDITS) begin
            errs++;
            $display("more results appeared during the stall than output credits allow");
         end
         if (in_cred != DEPTH) begin
            errs++;
            $display("not every input credit came back after the queue drained");
         end
         report(t, c0, e0);
      end
      $display("%0d results checked, %0d errors", chk0.chk_cnt, chk0.err_cnt + errs);
      if (chk0.err_cnt + errs == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: verif/exec_checker.sv
// Result checker: compares each out_valid result, in order, with the queued expected values
module exec_checker #(
   parameter int DATA_W = 16
) (
   input logic              clk,
   input logic              rst,
   input logic              out_valid,
   input logic [DATA_W-1:0] out_result,
   input logic              out_zero,
   input logic              out_ofl,
   input logic              out_lt,
   input logic              out_lte,
   input logic              out_pc_src,
   input logic [DATA_W-1:0] out_br_target,
   input logic [DATA_W-1:0] out_jr_target
);

   // Record layout: result, zero, ofl, lt, lte, pc_src, br_target, jr_target
   localparam int EXP_W = 3*DATA_W + 5;

   logic [EXP_W-1:0] exp_q [$];
   int               chk_cnt = 0;   // Results compared
   int               err_cnt = 0;

   task automatic expect_push(input logic [EXP_W-1:0] e);
      exp_q.push_back(e);
   endtask

   function automatic int pending();
      return exp_q.size();
   endfunction

   task automatic compare(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Outputs settle after the rising edge, so look at them on the falling one
   always @(negedge clk) begin
      logic [EXP_W-1:0] e;
      if (!rst && out_valid) begin
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("out_valid was raised with no operation outstanding");
         end else begin
            e = exp_q.pop_front();
            chk_cnt++;
            compare("out_result", out_result, e[EXP_W-1 -: DATA_W]);
            compare("out_zero", out_zero, e[2*DATA_W+4]);
            compare("out_ofl", out_ofl, e[2*DATA_W+3]);
            compare("out_lt", out_lt, e[2*DATA_W+2]);
            compare("out_lte", out_lte, e[2*DATA_W+1]);
            compare("out_pc_src", out_pc_src, e[2*DATA_W]);
            compare("out_br_target", out_br_target, e[2*DATA_W-1 -: DATA_W]);
            compare("out_jr_target", out_jr_target, e[DATA_W-1:0]);
         end
      end
   end

endmodule

// File: hdl/exec_top.sv
// Standalone execute unit: credit-based input queue, execute logic and result register
module exec_top import exec_pkg::*; #(
   parameter int DATA_W      = 16,
   parameter int DEPTH       = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid,
   input  alu_op_e           in_op,
   input  logic [DATA_W-1:0] in_a,
   input  logic [DATA_W-1:0] in_b,
   input  logic              in_cin,
   input  logic              in_inv_a,
   input  logic              in_inv_b,
   input  logic              in_sign,
   input  logic [DATA_W-1:0] in_pc_inc,
   input  logic              in_br,
   input  logic              in_jmp,
   input  br_cond_e          in_br_cond,
   input  logic              out_credit,
   output logic              in_credit,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_result,
   output logic              out_zero,
   output logic              out_ofl,
   output logic              out_lt,
   output logic              out_lte,
   output logic              out_pc_src,
   output logic [DATA_W-1:0] out_br_target,
   output logic [DATA_W-1:0] out_jr_target
);

   localparam int OP_W = $bits(alu_op_e);
   localparam int BC_W = $bits(br_cond_e);
   localparam int Q_W  = 3*DATA_W + OP_W + BC_W + 6;   // Plus six single-bit flags

   logic [Q_W-1:0]    q_in;
   logic [Q_W-1:0]    q_head;
   logic              q_not_empty;
   logic              pop;
   logic [OP_W-1:0]   h_op;
   logic [DATA_W-1:0] h_a;
   logic [DATA_W-1:0] h_b;
   logic              h_cin;
   logic              h_inv_a;
   logic              h_inv_b;
   logic              h_sign;
   logic [DATA_W-1:0] h_pc_inc;
   logic              h_br;
   logic              h_jmp;
   logic [BC_W-1:0]   h_br_cond;
   logic [DATA_W-1:0] ex_result;
   logic              ex_zero;
   logic              ex_ofl;
   logic              ex_lt;
   logic              ex_lte;
   logic              ex_pc_src;
   logic [DATA_W-1:0] ex_br_target;
   logic [DATA_W-1:0] ex_jr_target;

   // Same field order on both sides of the queue
   assign q_in = {in_op, in_a, in_b, in_cin, in_inv_a, in_inv_b, in_sign,
                  in_pc_inc, in_br, in_jmp, in_br_cond};
   assign {h_op, h_a, h_b, h_cin, h_inv_a, h_inv_b, h_sign,
           h_pc_inc, h_br, h_jmp, h_br_cond} = q_head;

   op_queue #(.WIDTH(Q_W), .DEPTH(DEPTH)) queue0 (
      .clk        (clk),
      .rst        (rst),
      .push       (in_valid),
      .push_data  (q_in),
      .pop        (pop),
      .head_data  (q_head),
      .not_empty  (q_not_empty),
      .credit_ret (in_credit)
   );

   execute #(.DATA_W(DATA_W)) exec0 (
      .opnd_a    (h_a),
      .opnd_b    (h_b),
      .cin       (h_cin),
      .op        (alu_op_e'(h_op)),
      .inv_a     (h_inv_a),
      .inv_b     (h_inv_b),
      .sign      (h_sign),
      .pc_inc    (h_pc_inc),
      .br_cond   (br_cond_e'(h_br_cond)),
      .br        (h_br),
      .jmp       (h_jmp),
      .check_en  (pop),   // Head is only meaningful when popped
      .result    (ex_result),
      .zero      (ex_zero),
      .ofl       (ex_ofl),
      .lt        (ex_lt),
      .lte       (ex_lte),
      .pc_src    (ex_pc_src),
      .br_target (ex_br_target),
      .jr_target (ex_jr_target)
   );

   result_stage #(.DATA_W(DATA_W), .OUT_CREDITS(OUT_CREDITS)) res0 (
      .clk           (clk),
      .rst           (rst),
      .not_empty     (q_not_empty),
      .out_credit    (out_credit),
      .ex_result     (ex_result),
      .ex_zero       (ex_zero),
      .ex_ofl        (ex_ofl),
      .ex_lt         (ex_lt),
      .ex_lte        (ex_lte),
      .ex_pc_src     (ex_pc_src),
      .ex_br_target  (ex_br_target),
      .ex_jr_target  (ex_jr_target),
      .pop           (pop),
      .out_valid     (out_valid),
      .out_result    (out_result),
      .out_zero      (out_zero),
      .out_ofl       (out_ofl),
      .out_lt        (out_lt),
      .out_lte       (out_lte),
      .out_pc_src    (out_pc_src),
      .out_br_target (out_br_target),
      .out_jr_target (out_jr_target)
   );

endmodule

// File: hdl/result_stage.sv
// Result stage: pops the queue against downstream credits, registers execute outputs
module result_stage #(
   parameter int DATA_W      = 16,
   parameter int OUT_CREDITS = 2
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              not_empty,
   input  logic              out_credit,
   input  logic [DATA_W-1:0] ex_result,
   input  logic              ex_zero,
   input  logic              ex_ofl,
   input  logic              ex_lt,
   input  logic              ex_lte,
   input  logic              ex_pc_src,
   input  logic [DATA_W-1:0] ex_br_target,
   input  logic [DATA_W-1:0] ex_jr_target,
   output logic              pop,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_result,
   output logic              out_zero,
   output logic              out_ofl,
   output logic              out_lt,
   output logic              out_lte,
   output logic              out_pc_src,
   output logic [DATA_W-1:0] out_br_target,
   output logic [DATA_W-1:0] out_jr_target
);

   // One spare bit so an underflow wrap lands above OUT_CREDITS
   localparam int CRED_W = $clog2(OUT_CREDITS + 1) + 1;

   logic [CRED_W-1:0] credits;

   assign pop = not_empty && (credits != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         credits   <= CRED_W'(OUT_CREDITS);
         out_valid <= 1'b0;
      end else begin
         out_valid <= pop;
         case ({pop, out_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;   // Spend and return cancel
         endcase
      end
   end

   // Payload captured with the pop, qualified downstream by out_valid
   always_ff @(posedge clk) begin
      if (pop) begin
         out_result    <= ex_result;
         out_zero      <= ex_zero;
         out_ofl       <= ex_ofl;
         out_lt        <= ex_lt;
         out_lte       <= ex_lte;
         out_pc_src    <= ex_pc_src;
         out_br_target <= ex_br_target;
         out_jr_target <= ex_jr_target;
      end
   end

   // Too many returns from downstream, or a wrap below zero
   a_credit_range: assert property (@(posedge clk) disable iff (rst)
                                    credits <= CRED_W'(OUT_CREDITS))
      else $error("result_stage: credit counter out of range (%0d)", credits);

endmodule

// File: hdl/op_queue.sv
// Operation queue: circular FIFO that returns one upstream credit per pop
module op_queue #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             push,
   input  logic [WIDTH-1:0] push_data,
   input  logic             pop,
   output logic [WIDTH-1:0] head_data,
   output logic             not_empty,
   output logic             credit_ret
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;

   // Wraps at DEPTH, so depths that are not a power of two work too
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full      = (count == CNT_W'(DEPTH));
   assign not_empty = (count != '0);
   assign head_data = mem[rd_ptr];   // Head visible the cycle after the push

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_ret <= 1'b0;
      end else begin
         credit_ret <= pop;   // One credit back per freed slot
         if (push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   // Upstream must never push more than the credits it was given
   a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
      else $error("op_queue: push while full");

   a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> not_empty)
      else $error("op_queue: pop while empty");

endmodule

// File: hdl/execute.sv
// Execute stage: ALU plus branch resolution, purely combinational
module execute import exec_pkg::*; #(
   parameter int DATA_W = 16
) (
   input  logic [DATA_W-1:0] opnd_a,
   input  logic [DATA_W-1:0] opnd_b,
   input  logic              cin,
   input  alu_op_e           op,
   input  logic              inv_a,
   input  logic              inv_b,
   input  logic              sign,
   input  logic [DATA_W-1:0] pc_inc,
   input  br_cond_e          br_cond,
   input  logic              br,
   input  logic              jmp,
   input  logic              check_en,
   output logic [DATA_W-1:0] result,
   output logic              zero,
   output logic              ofl,
   output logic              lt,
   output logic              lte,
   output logic              pc_src,
   output logic [DATA_W-1:0] br_target,
   output logic [DATA_W-1:0] jr_target
);

   alu #(.DATA_W(DATA_W)) alu0 (
      .in_a   (opnd_a),
      .in_b   (opnd_b),
      .cin    (cin),
      .op     (op),
      .inv_a  (inv_a),
      .inv_b  (inv_b),
      .sign   (sign),
      .result (result),
      .zero   (zero),
      .ofl    (ofl),
      .lt     (lt),
      .lte    (lte)
   );

   // EQ/NEQ follow the ALU result, LT/GTE the sign of raw operand a
   branch_resolve #(.DATA_W(DATA_W)) br0 (
      .zero      (zero),
      .a_msb     (opnd_a[DATA_W-1]),
      .br_cond   (br_cond),
      .br        (br),
      .jmp       (jmp),
      .pc_inc    (pc_inc),
      .opnd_a    (opnd_a),
      .opnd_b    (opnd_b),
      .pc_src    (pc_src),
      .br_target (br_target),
      .jr_target (jr_target)
   );

   // A popped queue entry must resolve to known values on every output
   always_comb begin
      if (check_en) begin
         a_no_x_out: assert final (!$isunknown({result, zero, ofl, lt, lte,
                                                 pc_src, br_target, jr_target}))
            else $error("execute: unknown value on an output for a popped operation");
      end
   end

endmodule

// File: hdl/branch_resolve.sv
// Branch resolver: condition select, PC source decision and both jump targets
module branch_resolve import exec_pkg::*; #(
   parameter int DATA_W = 16
) (
   input  logic              zero,
   input  logic              a_msb,
   input  br_cond_e          br_cond,
   input  logic              br,
   input  logic              jmp,
   input  logic [DATA_W-1:0] pc_inc,
   input  logic [DATA_W-1:0] opnd_a,
   input  logic [DATA_W-1:0] opnd_b,
   output logic              pc_src,
   output logic [DATA_W-1:0] br_target,
   output logic [DATA_W-1:0] jr_target
);

   logic take;

   always_comb begin
      take = 1'b0;
      case (br_cond)
         BR_EQ:  take = zero;
         BR_NEQ: take = ~zero;
         BR_LT:  take = a_msb;    // Sign bit of a
         BR_GTE: take = ~a_msb;
      endcase
   end

   // Unconditional jump wins over any branch condition
   assign pc_src = jmp | (br & take);

   // Branch offset counts halfwords
   assign br_target = pc_inc + (opnd_b << 1);
   assign jr_target = pc_inc + opnd_a;   // Register-relative jump

endmodule

// File: hdl/alu.sv
// ALU: rotates, shifts, add with carry-in, logic ops and compare flags on one word
module alu import exec_pkg::*; #(
   parameter int DATA_W = 16
) (
   input  logic [DATA_W-1:0] in_a,
   input  logic [DATA_W-1:0] in_b,
   input  logic              cin,
   input  alu_op_e           op,
   input  logic              inv_a,
   input  logic              inv_b,
   input  logic              sign,
   output logic [DATA_W-1:0] result,
   output logic              zero,
   output logic              ofl,
   output logic              lt,
   output logic              lte
);

   logic [DATA_W-1:0]   a_op;
   logic [DATA_W-1:0]   b_op;
   logic [3:0]          shamt;
   logic [2*DATA_W-1:0] rol_ext;
   logic [2*DATA_W-1:0] ror_ext;
   logic [DATA_W-1:0]   sum;
   logic                cout;
   logic                sovf;

   // Operand inversion, used for subtraction with cin = 1
   assign a_op = inv_a ? ~in_a : in_a;
   assign b_op = inv_b ? ~in_b : in_b;

   assign shamt = b_op[3:0];   // Only the low nibble counts

   // Rotates through a doubled copy of a
   assign rol_ext = {a_op, a_op} << shamt;
   assign ror_ext = {a_op, a_op} >> shamt;

   assign {cout, sum} = {1'b0, a_op} + {1'b0, b_op} + {{DATA_W{1'b0}}, cin};

   // Same-sign operands giving a result of the other sign
   assign sovf = (a_op[DATA_W-1] == b_op[DATA_W-1]) &&
                 (sum[DATA_W-1] != a_op[DATA_W-1]);

   always_comb begin
      unique case (op)
         OP_ROL: result = rol_ext[2*DATA_W-1:DATA_W];
         OP_SLL: result = a_op << shamt;
         OP_ROR: result = ror_ext[DATA_W-1:0];
         OP_SRL: result = a_op >> shamt;
         OP_ADD: result = sum;
         OP_OR:  result = a_op | b_op;
         OP_XOR: result = a_op ^ b_op;
         OP_AND: result = a_op & b_op;
      endcase
   end

   assign zero = (result == '0);
   assign ofl  = sign ? sovf : cout;   // Carry-out in unsigned mode

   // Comparison uses the operands as they arrived, before inversion
   always_comb begin
      if (sign) begin
         lt  = $signed(in_a) <  $signed(in_b);
         lte = $signed(in_a) <= $signed(in_b);
      end else begin
         lt  = in_a <  in_b;
         lte = in_a <= in_b;
      end
   end

endmodule

// File: hdl/exec_pkg.sv
// Execute stage types: ALU opcodes and branch condition codes
package exec_pkg;

   // ALU operation select, 3 bits
   // Shift group sits in the low half, logic group with ADD in the high half
   typedef enum logic [2:0] {
      OP_ROL = 3'b000,   // Rotate left
      OP_SLL = 3'b001,   // Shift left logical
      OP_ROR = 3'b010,   // Rotate right
      OP_SRL = 3'b011,   // Shift right logical
      OP_ADD = 3'b100,   // a + b + cin
      OP_OR  = 3'b101,
      OP_XOR = 3'b110,
      OP_AND = 3'b111
   } alu_op_e;

   // Branch condition select, 2 bits
   // EQ and NEQ look at the ALU zero flag, LT and GTE at the sign of operand a
   typedef enum logic [1:0] {
      BR_EQ  = 2'b00,    // Zero set
      BR_NEQ = 2'b01,    // Zero clear
      BR_LT  = 2'b10,    // a negative
      BR_GTE = 2'b11     // a zero or positive
   } br_cond_e;

endpackage
